//--- all.f
logic/csr_pkg.sv
logic/csr_counters.sv
logic/csr_file.sv
logic/csr_trap_ctrl.sv
logic/csr_stage.sv
tb/csr_stage_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module csr_stage_tb -f all.f -o csr_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/csr_stage_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tb/csr_stage_tb.sv
`timescale 1ns/100ps

module csr_stage_tb;

    localparam int CLK_MHZ    = 4;
    localparam int RMW_OPS    = 12;
    localparam int CYC_GAP    = 7;
    localparam int TIME_GAP   = 3;
    // Full sequence stays well under 200 cycles, bound is several times that
    localparam int MAX_CYCLES = 2000;

    logic                clk;
    logic                arst_n;
    csr_pkg::csr_cmd_e   csr_cmd;
    logic [31:0]         csr_op1;
    logic [11:0]         csr_addr;
    logic                flush;
    logic                interrupt_ready;
    logic                mtimecmp_we;
    logic [63:0]         mtimecmp_wdata;
    csr_pkg::csr_cmd_e   csr_cmd_out;
    logic [31:0]         csr_rdata;
    logic [31:0]         trap_vector;
    logic                stall_may_interrupt;

    int                  cycles = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  test_num = 0;
    int                  test_checks;
    int                  test_errors;
    logic [31:0]         rng_state;

    // Reference state kept alongside the DUT
    logic [31:0]         sh_mscratch;
    logic [31:0]         sh_mtvec;
    logic [31:0]         sh_mepc;
    csr_pkg::priv_mode_e exp_mode;
    csr_pkg::priv_mode_e exp_mpp;
    logic                exp_mie;
    logic                exp_mpie;

    csr_stage #(
        .CLK_MHZ             (CLK_MHZ)
    ) csr_stage_i (
        .clk                 (clk),
        .arst_n              (arst_n),
        .csr_cmd             (csr_cmd),
        .csr_op1             (csr_op1),
        .csr_addr            (csr_addr),
        .flush               (flush),
        .interrupt_ready     (interrupt_ready),
        .mtimecmp_we         (mtimecmp_we),
        .mtimecmp_wdata      (mtimecmp_wdata),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Hard stop if the sequence hangs
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Write data rule of stage 2
    function automatic logic [31:0] rmw_result(input csr_pkg::csr_cmd_e cmd,
                                               input logic [31:0] old, input logic [31:0] op);
        if (cmd == csr_pkg::CSR_S)
            return old | op;
        else if (cmd == csr_pkg::CSR_C)
            return old & ~op;
        return op;
    endfunction

    // Only mpp, mpie and mie ever leave zero in these tests
    function automatic logic [31:0] mstatus_model();
        return {19'b0, exp_mpp, 3'b0, exp_mpie, 3'b0, exp_mie, 3'b0};
    endfunction

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_cmd(input csr_pkg::csr_cmd_e exp, input string what);
        checks++;
        assert (csr_cmd_out == exp) else begin
            $display("FAIL %0t: %s, csr_cmd_out %0d expected %0d", $time, what,
                     csr_cmd_out, exp);
            errors++;
        end
    endtask

    // Drive one command, return at the drive point after its sampling edge
    task automatic issue(input csr_pkg::csr_cmd_e cmd, input logic [11:0] addr,
                         input logic [31:0] op, input logic kill);
        csr_cmd  = cmd;
        csr_addr = addr;
        csr_op1  = op;
        flush    = kill;
        @(posedge clk);
        #10;
        csr_cmd  = csr_pkg::CSR_X;
        csr_op1  = 32'h0;
        flush    = 1'b0;
    endtask

    // Plain read, no command so nothing is written back
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        issue(csr_pkg::CSR_X, addr, 32'h0, 1'b0);
        data = csr_rdata;
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp,
                               input string what);
        issue(csr_pkg::CSR_X, addr, 32'h0, 1'b0);
        expect_eq(csr_rdata, exp, what);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic set_mtimecmp(input logic [63:0] value);
        mtimecmp_wdata = value;
        mtimecmp_we    = 1'b1;
        @(posedge clk);
        #10;
        mtimecmp_we    = 1'b0;
    endtask

    task automatic wait_for_stall(input int limit);
        int n;
        n = 0;
        while (!stall_may_interrupt && n < limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!stall_may_interrupt) begin
            $display("Error at %0t: stall_may_interrupt did not rise within %0d cycles",
                     $time, limit);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_num++;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin
        csr_pkg::csr_cmd_e cmd;
        logic [31:0]       r;
        logic [31:0]       op;
        logic [31:0]       old_val;
        logic [31:0]       new_val;
        logic [31:0]       t0;
        logic [31:0]       t1;
        logic [11:0]       addr;

        arst_n          = 1'b0;
        csr_cmd         = csr_pkg::CSR_X;
        csr_op1         = 32'h0;
        csr_addr        = 12'h0;
        flush           = 1'b0;
        interrupt_ready = 1'b0;
        mtimecmp_we     = 1'b0;
        mtimecmp_wdata  = 64'h0;
        rng_state       = 32'h681e11ca;
        sh_mscratch     = 32'h0;
        sh_mtvec        = 32'h0;
        sh_mepc         = 32'h0;
        exp_mode        = csr_pkg::MODE_MACHINE;
        exp_mpp         = csr_pkg::MODE_MACHINE;
        exp_mie         = 1'b0;
        exp_mpie        = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // Outputs straight out of reset
        begin_test();
        expect_cmd(csr_pkg::CSR_X, "cmd out after reset");
        expect_eq(csr_rdata, 32'h0, "rdata after reset");
        expect_eq(trap_vector, 32'h0, "trap_vector after reset");
        expect_eq({31'b0, stall_may_interrupt}, 32'h0, "stall after reset");
        read_expect(csr_pkg::CSR_ADDR_MSTATUS, mstatus_model(), "mstatus after reset");
        read_expect(csr_pkg::CSR_ADDR_MTVEC, sh_mtvec, "mtvec after reset");
        end_test("reset_state");

        // Write, set and clear in turn with random operands on two full-width CSRs
        begin_test();
        for (int i = 0; i < RMW_OPS; i++) begin
            r  = next_rand();
            op = next_rand();
            case (i % 3)
                1:       cmd = csr_pkg::CSR_S;
                2:       cmd = csr_pkg::CSR_C;
                default: cmd = csr_pkg::CSR_W;
            endcase
            addr    = r[2] ? csr_pkg::CSR_ADDR_MTVEC : csr_pkg::CSR_ADDR_MSCRATCH;
            old_val = r[2] ? sh_mtvec : sh_mscratch;
            new_val = rmw_result(cmd, old_val, op);
            issue(cmd, addr, op, 1'b0);
            expect_eq(csr_rdata, old_val, "rmw returns old value");
            // Write lands on the same edge as this read
            read_expect(addr, old_val, "back-to-back read");
            read_expect(addr, new_val, "read after write");
            if (r[2])
                sh_mtvec = new_val;
            else
                sh_mscratch = new_val;
        end
        end_test("read_modify_write");

        // Implemented bits only
        begin_test();
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MIE, 32'hffff_ffff, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MIDELEG, 32'hffff_ffff, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSTATUSH, 32'hffff_ffff, 1'b0);
        issue(csr_pkg::CSR_W, 12'h7c0, 32'hffff_ffff, 1'b0);
        read_expect(csr_pkg::CSR_ADDR_MIE, 32'h0000_0aaa, "mie mask");
        read_expect(csr_pkg::CSR_ADDR_MIDELEG, 32'h0000_0080, "mideleg mask");
        read_expect(csr_pkg::CSR_ADDR_MSTATUSH, 32'h0000_0030, "mstatush mask");
        read_expect(12'h7c0, 32'h0, "unlisted address");
        // Counter write is dropped, counting goes on
        read_csr(csr_pkg::CSR_ADDR_CYCLE, t0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_CYCLE, 32'h0, 1'b0);
        idle(1);
        read_csr(csr_pkg::CSR_ADDR_CYCLE, t1);
        expect_eq(t1 - t0, 32'd3, "cycle after write");
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MIDELEG, 32'h0, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MIE, 32'h0, 1'b0);
        end_test("field_masks");

        // Killed write
        begin_test();
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSCRATCH, ~sh_mscratch, 1'b1);
        expect_cmd(csr_pkg::CSR_X, "cmd out under flush");
        idle(1);
        read_expect(csr_pkg::CSR_ADDR_MSCRATCH, sh_mscratch, "mscratch after flush");
        issue(csr_pkg::CSR_S, csr_pkg::CSR_ADDR_MSCRATCH, 32'h0, 1'b0);
        expect_cmd(csr_pkg::CSR_S, "cmd out without flush");
        end_test("flush");

        // Counter spacing
        begin_test();
        read_csr(csr_pkg::CSR_ADDR_CYCLE, t0);
        idle(CYC_GAP - 1);
        read_csr(csr_pkg::CSR_ADDR_CYCLE, t1);
        expect_eq(t1 - t0, CYC_GAP, "cycle delta");
        read_csr(csr_pkg::CSR_ADDR_TIME, t0);
        idle(CLK_MHZ * TIME_GAP - 1);
        read_csr(csr_pkg::CSR_ADDR_TIME, t1);
        expect_eq(t1 - t0, TIME_GAP, "time delta");
        read_expect(csr_pkg::CSR_ADDR_CYCLEH, 32'h0, "cycleh");
        end_test("counters");

        // Timer interrupt, mret twice, then ecall from user
        begin_test();
        sh_mtvec = next_rand() & 32'hffff_fffc;
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MTVEC, sh_mtvec, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MIE, 32'h0000_0080, 1'b0);
        // mpp to user so the trap entry has to save the mode
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSTATUS, 32'h0000_0008, 1'b0);
        exp_mie = 1'b1;
        exp_mpp = csr_pkg::MODE_USER;
        idle(1);
        expect_eq({31'b0, stall_may_interrupt}, 32'h0, "stall before timer");
        set_mtimecmp(64'h0);
        wait_for_stall(20);
        interrupt_ready = 1'b1;
        @(posedge clk);
        #10;
        interrupt_ready = 1'b0;
        exp_mpie = exp_mie;
        exp_mie  = 1'b0;
        exp_mpp  = exp_mode;
        exp_mode = csr_pkg::MODE_MACHINE;
        expect_cmd(csr_pkg::CSR_ECALL, "interrupt as ecall");
        expect_eq(trap_vector, sh_mtvec, "trap_vector on interrupt");
        expect_eq({31'b0, stall_may_interrupt}, 32'h0, "stall after interrupt");
        set_mtimecmp(64'hffff_ffff_ffff_ffff);
        read_expect(csr_pkg::CSR_ADDR_MSTATUS, mstatus_model(), "mstatus after interrupt");

        sh_mepc = ~sh_mtvec & 32'hffff_fffc;
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MEPC, sh_mepc, 1'b0);
        for (int k = 0; k < 2; k++) begin
            issue(csr_pkg::CSR_MRET, csr_pkg::CSR_ADDR_MSTATUS, 32'h0, 1'b0);
            expect_cmd(csr_pkg::CSR_MRET, "mret out");
            idle(1);
            exp_mode = exp_mpp;
            exp_mie  = exp_mpie;
            exp_mpp  = csr_pkg::MODE_USER;
            expect_eq(trap_vector, sh_mepc, "trap_vector on mret");
            read_expect(csr_pkg::CSR_ADDR_MSTATUS, mstatus_model(), "mstatus after mret");
        end

        // Stale cause so the ecall update is visible
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MCAUSE, 32'hffff_ffff, 1'b0);
        issue(csr_pkg::CSR_ECALL, csr_pkg::CSR_ADDR_MCAUSE, 32'h0, 1'b0);
        expect_cmd(csr_pkg::CSR_ECALL, "ecall out");
        idle(1);
        new_val  = {30'b0, exp_mode};
        exp_mode = csr_pkg::MODE_MACHINE;
        expect_eq(trap_vector, sh_mtvec, "trap_vector on ecall");
        read_expect(csr_pkg::CSR_ADDR_MCAUSE, new_val, "mcause after ecall");
        end_test("traps");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- logic/csr_stage.sv
`timescale 1ns/100ps

module csr_stage #(
    parameter int CLK_MHZ = 27
) (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_cmd_e   csr_cmd,
    input  logic [31:0]         csr_op1,
    input  logic [11:0]         csr_addr,
    input  logic                flush,
    input  logic                interrupt_ready,
    input  logic                mtimecmp_we,
    input  logic [63:0]         mtimecmp_wdata,
    output csr_pkg::csr_cmd_e   csr_cmd_out,
    output logic [31:0]         csr_rdata,
    output logic [31:0]         trap_vector,
    output logic                stall_may_interrupt
);

    // Counter unit outputs
    logic [63:0]         cycle;
    logic [63:0]         mtime;
    logic                timer_pending;

    // CSR state toward the trap controller
    csr_pkg::csr_cmd_e   exec_cmd;
    logic                mstatus_mie;
    logic                mstatus_sie;
    csr_pkg::priv_mode_e mstatus_mpp;
    logic                mie_mtie;
    logic                mideleg_mtie;
    logic [31:0]         mtvec;
    logic [31:0]         mepc;

    // Trap pulses back to the CSR file
    csr_pkg::priv_mode_e mode;
    logic                irq_take;
    logic                irq_to_s;
    logic                ecall_take;
    logic                mret_take;

    csr_counters #(
        .CLK_MHZ        (CLK_MHZ)
    ) counters_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .mtimecmp_we    (mtimecmp_we),
        .mtimecmp_wdata (mtimecmp_wdata),
        .cycle          (cycle),
        .mtime          (mtime),
        .timer_pending  (timer_pending)
    );

    csr_file file_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .csr_cmd        (csr_cmd),
        .csr_op1        (csr_op1),
        .csr_addr       (csr_addr),
        .flush          (flush),
        .cycle          (cycle),
        .mtime          (mtime),
        .irq_take       (irq_take),
        .irq_to_s       (irq_to_s),
        .ecall_take     (ecall_take),
        .mret_take      (mret_take),
        .mode           (mode),
        .csr_rdata      (csr_rdata),
        .exec_cmd       (exec_cmd),
        .mstatus_mie    (mstatus_mie),
        .mstatus_sie    (mstatus_sie),
        .mstatus_mpp    (mstatus_mpp),
        .mie_mtie       (mie_mtie),
        .mideleg_mtie   (mideleg_mtie),
        .mtvec          (mtvec),
        .mepc           (mepc)
    );

    csr_trap_ctrl trap_i (
        .clk                 (clk),
        .arst_n              (arst_n),
        .csr_cmd             (csr_cmd),
        .flush               (flush),
        .interrupt_ready     (interrupt_ready),
        .timer_pending       (timer_pending),
        .exec_cmd            (exec_cmd),
        .mstatus_mie         (mstatus_mie),
        .mstatus_sie         (mstatus_sie),
        .mstatus_mpp         (mstatus_mpp),
        .mie_mtie            (mie_mtie),
        .mideleg_mtie        (mideleg_mtie),
        .mtvec               (mtvec),
        .mepc                (mepc),
        .mode                (mode),
        .irq_take            (irq_take),
        .irq_to_s            (irq_to_s),
        .ecall_take          (ecall_take),
        .mret_take           (mret_take),
        .csr_cmd_out         (csr_cmd_out),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

endmodule

//--- logic/csr_trap_ctrl.sv
`timescale 1ns/100ps

module csr_trap_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_cmd_e   csr_cmd,
    input  logic                flush,
    input  logic                interrupt_ready,
    input  logic                timer_pending,
    input  csr_pkg::csr_cmd_e   exec_cmd,
    input  logic                mstatus_mie,
    input  logic                mstatus_sie,
    input  csr_pkg::priv_mode_e mstatus_mpp,
    input  logic                mie_mtie,
    input  logic                mideleg_mtie,
    input  logic [31:0]         mtvec,
    input  logic [31:0]         mepc,
    output csr_pkg::priv_mode_e mode,
    output logic                irq_take,
    output logic                irq_to_s,
    output logic                ecall_take,
    output logic                mret_take,
    output csr_pkg::csr_cmd_e   csr_cmd_out,
    output logic [31:0]         trap_vector,
    output logic                stall_may_interrupt
);

    logic m_irq_ok;
    logic s_irq_ok;

    // M-mode keeps the timer, undelegated
    assign m_irq_ok = (mode == csr_pkg::MODE_MACHINE) && !mideleg_mtie && mstatus_mie;
    // S-mode takes it only when delegated
    assign s_irq_ok = (mode == csr_pkg::MODE_SUPERVISOR) && mideleg_mtie && mstatus_sie;

    // Core holds its front end while this is high
    assign stall_may_interrupt = timer_pending && mie_mtie && (m_irq_ok || s_irq_ok);

    assign irq_take = stall_may_interrupt && interrupt_ready;
    assign irq_to_s = mideleg_mtie;

    // Stage 2 ecall and mret, the interrupt wins a collision
    assign ecall_take = (exec_cmd == csr_pkg::CSR_ECALL) && !irq_take;
    assign mret_take  = (exec_cmd == csr_pkg::CSR_MRET) && !irq_take;

    // Command out, interrupt shows up as an ecall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_cmd_out <= csr_pkg::CSR_X;
        end else if (irq_take) begin
            csr_cmd_out <= csr_pkg::CSR_ECALL;
        end else begin
            csr_cmd_out <= flush ? csr_pkg::CSR_X : csr_cmd;
        end
    end

    // Privilege mode and jump target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= csr_pkg::MODE_MACHINE;
            trap_vector <= '0;
        end else if (irq_take) begin
            // No stvec, both sides vector through mtvec
            mode        <= irq_to_s ? csr_pkg::MODE_SUPERVISOR : csr_pkg::MODE_MACHINE;
            trap_vector <= mtvec;
        end else if (ecall_take) begin
            mode        <= csr_pkg::MODE_MACHINE;
            trap_vector <= mtvec;
        end else if (mret_take) begin
            mode        <= mstatus_mpp;
            trap_vector <= mepc;
        end
    end

    // Reserved level never reached, also via mpp from the CSR file
    a_mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        mode != 2'd2);

    // Taken interrupt needs the idle pipe
    a_irq_ready: assert property (@(posedge clk) disable iff (!arst_n)
        irq_take |-> interrupt_ready);

endmodule

//--- logic/csr_file.sv
`timescale 1ns/100ps

module csr_file (
    input  logic                clk,
    input  logic                arst_n,
    input  csr_pkg::csr_cmd_e   csr_cmd,
    input  logic [31:0]         csr_op1,
    input  logic [11:0]         csr_addr,
    input  logic                flush,
    input  logic [63:0]         cycle,
    input  logic [63:0]         mtime,
    input  logic                irq_take,
    input  logic                irq_to_s,
    input  logic                ecall_take,
    input  logic                mret_take,
    input  csr_pkg::priv_mode_e mode,
    output logic [31:0]         csr_rdata,
    output csr_pkg::csr_cmd_e   exec_cmd,
    output logic                mstatus_mie,
    output logic                mstatus_sie,
    output csr_pkg::priv_mode_e mstatus_mpp,
    output logic                mie_mtie,
    output logic                mideleg_mtie,
    output logic [31:0]         mtvec,
    output logic [31:0]         mepc
);

    // mstatus fields besides the exported ones
    logic        mstatus_sd;
    logic        mstatus_tsr;
    logic        mstatus_tw;
    logic        mstatus_tvm;
    logic        mstatus_mxr;
    logic        mstatus_sum;
    logic        mstatus_mprv;
    logic [1:0]  mstatus_xs;
    logic [1:0]  mstatus_fs;
    logic [1:0]  mstatus_vs;
    logic        mstatus_spp;
    logic        mstatus_mpie;
    logic        mstatus_ube;
    logic        mstatus_spie;
    logic        mstatush_mbe;
    logic        mstatush_sbe;

    // Interrupt enables, only mtie has an effect
    logic        mie_meie;
    logic        mie_seie;
    logic        mie_stie;
    logic        mie_msie;
    logic        mie_ssie;

    logic [31:0] medeleg;
    logic [31:0] mscratch;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mip;

    csr_pkg::csr_cmd_e s1_cmd;
    logic [31:0]       rd_val;
    logic [11:0]       s2_addr;
    logic [31:0]       s2_op1;
    logic [31:0]       wdata;
    logic              s2_write;

    // Branch hazard kills the incoming command
    assign s1_cmd = flush ? csr_pkg::CSR_X : csr_cmd;

    // Stage 1 read mux
    always_comb begin
        case (csr_addr)
            csr_pkg::CSR_ADDR_CYCLE:    rd_val = cycle[31:0];
            csr_pkg::CSR_ADDR_TIME:     rd_val = mtime[31:0];
            csr_pkg::CSR_ADDR_CYCLEH:   rd_val = cycle[63:32];
            csr_pkg::CSR_ADDR_TIMEH:    rd_val = mtime[63:32];
            csr_pkg::CSR_ADDR_MSTATUS:  rd_val = {mstatus_sd, 8'b0, mstatus_tsr, mstatus_tw,
                                                  mstatus_tvm, mstatus_mxr, mstatus_sum,
                                                  mstatus_mprv, mstatus_xs, mstatus_fs,
                                                  mstatus_mpp, mstatus_vs, mstatus_spp,
                                                  mstatus_mpie, mstatus_ube, mstatus_spie,
                                                  1'b0, mstatus_mie, 1'b0, mstatus_sie, 1'b0};
            csr_pkg::CSR_ADDR_MEDELEG:  rd_val = medeleg;
            csr_pkg::CSR_ADDR_MIDELEG:  rd_val = {24'b0, mideleg_mtie, 7'b0};
            // Odd enable bits only
            csr_pkg::CSR_ADDR_MIE:      rd_val = {20'b0, mie_meie, 1'b0, mie_seie, 1'b0,
                                                  mie_mtie, 1'b0, mie_stie, 1'b0,
                                                  mie_msie, 1'b0, mie_ssie, 1'b0};
            csr_pkg::CSR_ADDR_MTVEC:    rd_val = mtvec;
            csr_pkg::CSR_ADDR_MSTATUSH: rd_val = {26'b0, mstatush_mbe, mstatush_sbe, 4'b0};
            csr_pkg::CSR_ADDR_MSCRATCH: rd_val = mscratch;
            csr_pkg::CSR_ADDR_MEPC:     rd_val = mepc;
            csr_pkg::CSR_ADDR_MCAUSE:   rd_val = mcause;
            csr_pkg::CSR_ADDR_MTVAL:    rd_val = mtval;
            csr_pkg::CSR_ADDR_MIP:      rd_val = mip;
            default:                    rd_val = 32'b0;
        endcase
    end

    // Old value out, command moves to stage 2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_rdata <= '0;
            exec_cmd  <= csr_pkg::CSR_X;
        end else begin
            csr_rdata <= rd_val;
            exec_cmd  <= s1_cmd;
        end
    end

    always_ff @(posedge clk) begin
        s2_addr <= csr_addr;
        s2_op1  <= csr_op1;
    end

    // Stage 2 write data from the registered old value
    always_comb begin
        case (exec_cmd)
            csr_pkg::CSR_W: wdata = s2_op1;
            csr_pkg::CSR_S: wdata = csr_rdata | s2_op1;
            csr_pkg::CSR_C: wdata = csr_rdata & ~s2_op1;
            default:        wdata = 32'b0;
        endcase
    end

    assign s2_write = (exec_cmd == csr_pkg::CSR_W) || (exec_cmd == csr_pkg::CSR_S) ||
                      (exec_cmd == csr_pkg::CSR_C);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_sd   <= 1'b0;
            mstatus_tsr  <= 1'b0;
            mstatus_tw   <= 1'b0;
            mstatus_tvm  <= 1'b0;
            mstatus_mxr  <= 1'b0;
            mstatus_sum  <= 1'b0;
            mstatus_mprv <= 1'b0;
            mstatus_xs   <= 2'b0;
            mstatus_fs   <= 2'b0;
            mstatus_mpp  <= csr_pkg::MODE_MACHINE;
            mstatus_vs   <= 2'b0;
            mstatus_spp  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_ube  <= 1'b0;
            mstatus_spie <= 1'b0;
            mstatus_mie  <= 1'b0;
            mstatus_sie  <= 1'b0;
            mstatush_mbe <= 1'b0;
            mstatush_sbe <= 1'b0;
            mie_meie     <= 1'b0;
            mie_seie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_stie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_ssie     <= 1'b0;
            mideleg_mtie <= 1'b0;
            medeleg      <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mip          <= '0;
        end else if (irq_take) begin
            // Timer trap entry, M or S side
            if (irq_to_s) begin
                mstatus_spie <= mstatus_sie;
                mstatus_sie  <= 1'b0;
            end else begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= mode;
            end
        end else if (ecall_take) begin
            // Cause 0/1/3 tracks the calling mode
            mcause <= {30'b0, mode};
        end else if (mret_take) begin
            mstatus_mie <= mstatus_mpie;
            mstatus_mpp <= csr_pkg::MODE_USER;
            if (mstatus_mpp != csr_pkg::MODE_MACHINE) begin
                mstatus_mprv <= 1'b0;
            end
        end else if (s2_write) begin
            case (s2_addr)
                csr_pkg::CSR_ADDR_MSTATUS: begin
                    mstatus_sd   <= wdata[31];
                    mstatus_tsr  <= wdata[22];
                    mstatus_tw   <= wdata[21];
                    mstatus_tvm  <= wdata[20];
                    mstatus_mxr  <= wdata[19];
                    mstatus_sum  <= wdata[18];
                    mstatus_mprv <= wdata[17];
                    mstatus_xs   <= wdata[16:15];
                    mstatus_fs   <= wdata[14:13];
                    // Reserved level 2 is not accepted
                    if (wdata[12:11] != 2'b10) begin
                        mstatus_mpp <= csr_pkg::priv_mode_e'(wdata[12:11]);
                    end
                    mstatus_vs   <= wdata[10:9];
                    mstatus_spp  <= wdata[8];
                    mstatus_mpie <= wdata[7];
                    mstatus_ube  <= wdata[6];
                    mstatus_spie <= wdata[5];
                    mstatus_mie  <= wdata[3];
                    mstatus_sie  <= wdata[1];
                end
                csr_pkg::CSR_ADDR_MEDELEG:  medeleg <= wdata;
                csr_pkg::CSR_ADDR_MIDELEG:  mideleg_mtie <= wdata[7];
                csr_pkg::CSR_ADDR_MIE: begin
                    mie_meie <= wdata[11];
                    mie_seie <= wdata[9];
                    mie_mtie <= wdata[7];
                    mie_stie <= wdata[5];
                    mie_msie <= wdata[3];
                    mie_ssie <= wdata[1];
                end
                csr_pkg::CSR_ADDR_MTVEC:    mtvec <= wdata;
                csr_pkg::CSR_ADDR_MSTATUSH: begin
                    mstatush_mbe <= wdata[5];
                    mstatush_sbe <= wdata[4];
                end
                csr_pkg::CSR_ADDR_MSCRATCH: mscratch <= wdata;
                csr_pkg::CSR_ADDR_MEPC:     mepc <= wdata;
                csr_pkg::CSR_ADDR_MCAUSE:   mcause <= wdata;
                csr_pkg::CSR_ADDR_MTVAL:    mtval <= wdata;
                csr_pkg::CSR_ADDR_MIP:      mip <= wdata;
                // Counters and unlisted addresses ignore writes
                default: ;
            endcase
        end
    end

    // Trap pulses from the controller only arrive with stage 2 idle
    a_trap_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        (irq_take || ecall_take || mret_take) |-> !s2_write);

endmodule

//--- logic/csr_counters.sv
`timescale 1ns/100ps

module csr_counters #(
    parameter int CLK_MHZ = 27
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mtimecmp_we,
    input  logic [63:0] mtimecmp_wdata,
    output logic [63:0] cycle,
    output logic [63:0] mtime,
    output logic        timer_pending
);

    localparam int PRE_W = $clog2(CLK_MHZ + 1);

    logic [PRE_W-1:0] prescale;
    logic [63:0]      mtimecmp;
    logic             tick;

    // Last prescaler count closes one microsecond
    assign tick = (prescale == PRE_W'(CLK_MHZ - 1));

    // Free-running cycle counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // Microsecond time base
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale <= '0;
            mtime    <= '0;
        end else if (tick) begin
            prescale <= '0;
            mtime    <= mtime + 64'd1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Compare value, all ones keeps the timer quiet
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else if (mtimecmp_we) begin
            mtimecmp <= mtimecmp_wdata;
        end
    end

    // Level, stays up until mtimecmp moves past mtime
    assign timer_pending = (mtime >= mtimecmp);

    // Time only moves forward, one tick at a time
    a_time_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
        (mtime - $past(mtime)) <= 64'd1);

    a_prescale_range: assert property (@(posedge clk) disable iff (!arst_n)
        prescale < PRE_W'(CLK_MHZ));

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    // Commands carried through the CSR stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Privilege levels, encoding 2 is reserved
    typedef enum logic [1:0] {
        MODE_USER       = 2'd0,
        MODE_SUPERVISOR = 2'd1,
        MODE_MACHINE    = 2'd3
    } priv_mode_e;

    // Counters and timers, read only
    localparam logic [11:0] CSR_ADDR_CYCLE    = 12'hc00;
    localparam logic [11:0] CSR_ADDR_TIME     = 12'hc01;
    localparam logic [11:0] CSR_ADDR_CYCLEH   = 12'hc80;
    localparam logic [11:0] CSR_ADDR_TIMEH    = 12'hc81;

    // Machine trap setup
    localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_ADDR_MEDELEG  = 12'h302;
    localparam logic [11:0] CSR_ADDR_MIDELEG  = 12'h303;
    localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_ADDR_MSTATUSH = 12'h310;

    // Machine trap handling
    localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_ADDR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;

endpackage
